/* src/rv_core_defs.svh */
`ifndef RV_CORE_DEFS_SVH
`define RV_CORE_DEFS_SVH

// first fetch address after reset
`define RV_RESET_PC 32'h0000_0000

// datapath and instruction widths
`define RV_XLEN 32
`define RV_ILEN 32

// architectural register count, x0 included
`define RV_NUM_REGS 32

// major opcodes of the supported subset
`define RV_OP_REG    7'b0110011
`define RV_OP_IMM    7'b0010011
`define RV_OP_LUI    7'b0110111
`define RV_OP_BRANCH 7'b1100011
`define RV_OP_JAL    7'b1101111

`endif

/* src/rv_core_pkg.sv */
`default_nettype none

`include "rv_core_defs.svh"

package rv_core_pkg;

    typedef logic [`RV_XLEN-1:0] word_t;
    typedef logic [`RV_XLEN-1:0] addr_t;
    typedef logic [7:0]          byte_t;
    typedef logic [4:0]          reg_idx_t;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_PASS_B
    } alu_op_e;

    // byte-serial fetch sequence
    typedef enum logic [2:0] {
        FS_IDLE,
        FS_ADDR0,
        FS_ADDR1,
        FS_ADDR2,
        FS_ADDR3,
        FS_LAST,
        FS_WAIT
    } fetch_state_e;

    typedef struct packed {
        logic               valid;
        addr_t              pc;
        logic [`RV_ILEN-1:0] inst;
    } fetch_t;

    typedef struct packed {
        logic     valid;
        addr_t    pc;
        word_t    rs1_val;
        word_t    op_b;
        word_t    imm;
        reg_idx_t rd;
        alu_op_e  alu_op;
        logic     wr_en;
        logic     is_branch;
        logic     br_ne;
        logic     is_jal;
        logic     illegal;
    } decode_t;

    typedef struct packed {
        logic     valid;
        addr_t    pc;
        word_t    result;
        logic     br_taken;
        addr_t    target;
        reg_idx_t rd;
        logic     wr_en;
        logic     is_jal;
        logic     illegal;
    } exec_t;

    // write-back trace as seen at the top level
    typedef struct packed {
        logic     valid;
        addr_t    pc;
        reg_idx_t rd;
        word_t    data;
    } wb_t;

endpackage

`default_nettype wire

/* src/byte_fetch.sv */
`timescale 1ns/10ps
`default_nettype none

`include "rv_core_defs.svh"

module byte_fetch import rv_core_pkg::*; (
    input  wire   clk,
    input  wire   rst_n_i,
    input  byte_t mem_byte_i,
    input  logic  next_valid_i,
    input  addr_t next_pc_i,
    input  logic  halt_i,
    output addr_t mem_addr_o,
    output logic  mem_req_o,
    output fetch_t fetch_o
);

    fetch_state_e state_q;
    addr_t        pc_q;
    byte_t        byte0_q;
    byte_t        byte1_q;
    byte_t        byte2_q;
    fetch_t       fetch_q;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            state_q       <= FS_IDLE;
            pc_q          <= `RV_RESET_PC;
            fetch_q.valid <= 1'b0;
        end else begin
            fetch_q.valid <= 1'b0;
            case (state_q)
                FS_IDLE: begin
                    state_q <= FS_ADDR0;
                end
                FS_ADDR0: begin
                    state_q <= FS_ADDR1;
                end
                // memory answers one cycle after the address
                FS_ADDR1: begin
                    byte0_q <= mem_byte_i;
                    state_q <= FS_ADDR2;
                end
                FS_ADDR2: begin
                    byte1_q <= mem_byte_i;
                    state_q <= FS_ADDR3;
                end
                FS_ADDR3: begin
                    byte2_q <= mem_byte_i;
                    state_q <= FS_LAST;
                end
                // little endian, byte at pc is the lsb
                FS_LAST: begin
                    fetch_q.valid <= 1'b1;
                    fetch_q.pc    <= pc_q;
                    fetch_q.inst  <= {mem_byte_i, byte2_q, byte1_q, byte0_q};
                    state_q       <= FS_WAIT;
                end
                FS_WAIT: begin
                    if (next_valid_i && !halt_i) begin
                        pc_q    <= next_pc_i;
                        state_q <= FS_ADDR0;
                    end
                end
                default: begin
                    state_q <= FS_IDLE;
                end
            endcase
        end
    end

    always_comb begin
        case (state_q)
            FS_ADDR1: mem_addr_o = pc_q + 32'd1;
            FS_ADDR2: mem_addr_o = pc_q + 32'd2;
            FS_ADDR3: mem_addr_o = pc_q + 32'd3;
            default:  mem_addr_o = pc_q;
        endcase
    end

    assign mem_req_o = (state_q == FS_ADDR0) || (state_q == FS_ADDR1) ||
                       (state_q == FS_ADDR2) || (state_q == FS_ADDR3);

    assign fetch_o = fetch_q;

endmodule

`default_nettype wire

/* src/inst_decode.sv */
`timescale 1ns/10ps
`default_nettype none

`include "rv_core_defs.svh"

module inst_decode import rv_core_pkg::*; (
    input  wire      clk,
    input  wire      rst_n_i,
    input  fetch_t   fetch_i,
    input  word_t    rs1_data_i,
    input  word_t    rs2_data_i,
    output reg_idx_t rs1_idx_o,
    output reg_idx_t rs2_idx_o,
    output decode_t  dec_o
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    reg_idx_t   rd;
    word_t      imm_i;
    word_t      imm_b;
    word_t      imm_j;
    word_t      imm_u;
    decode_t    dec_d;
    decode_t    dec_q;

    assign opcode    = fetch_i.inst[6:0];
    assign rd        = fetch_i.inst[11:7];
    assign funct3    = fetch_i.inst[14:12];
    assign rs1_idx_o = fetch_i.inst[19:15];
    assign rs2_idx_o = fetch_i.inst[24:20];
    assign funct7    = fetch_i.inst[31:25];

    // sign-extended immediates
    assign imm_i = {{20{fetch_i.inst[31]}}, fetch_i.inst[31:20]};
    assign imm_b = {{19{fetch_i.inst[31]}}, fetch_i.inst[31], fetch_i.inst[7],
                    fetch_i.inst[30:25], fetch_i.inst[11:8], 1'b0};
    assign imm_j = {{11{fetch_i.inst[31]}}, fetch_i.inst[31], fetch_i.inst[19:12],
                    fetch_i.inst[20], fetch_i.inst[30:21], 1'b0};
    assign imm_u = {fetch_i.inst[31:12], 12'b0};

    always_comb begin
        dec_d           = '0;
        dec_d.valid     = fetch_i.valid;
        dec_d.pc        = fetch_i.pc;
        dec_d.rs1_val   = rs1_data_i;
        dec_d.op_b      = rs2_data_i;
        dec_d.imm       = imm_i;
        dec_d.rd        = rd;
        dec_d.alu_op    = ALU_ADD;
        case (opcode)
            `RV_OP_REG: begin
                case ({funct7, funct3})
                    {7'b0000000, 3'b000}: dec_d.alu_op = ALU_ADD;
                    {7'b0100000, 3'b000}: dec_d.alu_op = ALU_SUB;
                    {7'b0000000, 3'b010}: dec_d.alu_op = ALU_SLT;
                    {7'b0000000, 3'b100}: dec_d.alu_op = ALU_XOR;
                    {7'b0000000, 3'b110}: dec_d.alu_op = ALU_OR;
                    {7'b0000000, 3'b111}: dec_d.alu_op = ALU_AND;
                    default:              dec_d.illegal = 1'b1;
                endcase
            end
            `RV_OP_IMM: begin
                dec_d.op_b = imm_i;
                case (funct3)
                    3'b000:  dec_d.alu_op = ALU_ADD;
                    3'b010:  dec_d.alu_op = ALU_SLT;
                    3'b100:  dec_d.alu_op = ALU_XOR;
                    3'b110:  dec_d.alu_op = ALU_OR;
                    3'b111:  dec_d.alu_op = ALU_AND;
                    // shifts are not part of the subset
                    default: dec_d.illegal = 1'b1;
                endcase
            end
            `RV_OP_LUI: begin
                dec_d.op_b   = imm_u;
                dec_d.imm    = imm_u;
                dec_d.alu_op = ALU_PASS_B;
            end
            `RV_OP_BRANCH: begin
                dec_d.imm       = imm_b;
                dec_d.is_branch = 1'b1;
                dec_d.br_ne     = funct3[0];
                dec_d.illegal   = (funct3[2:1] != 2'b00);
            end
            `RV_OP_JAL: begin
                dec_d.imm    = imm_j;
                dec_d.is_jal = 1'b1;
            end
            default: begin
                dec_d.illegal = 1'b1;
            end
        endcase
        // x0 writes are dropped here so no trace appears
        dec_d.wr_en = !dec_d.illegal && !dec_d.is_branch && (rd != 5'd0);
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            dec_q.valid <= 1'b0;
        end else begin
            dec_q <= dec_d;
        end
    end

    assign dec_o = dec_q;

endmodule

`default_nettype wire

/* src/alu_execute.sv */
`timescale 1ns/10ps
`default_nettype none

module alu_execute import rv_core_pkg::*; (
    input  wire     clk,
    input  wire     rst_n_i,
    input  decode_t dec_i,
    output exec_t   exe_o
);

    word_t a;
    word_t b;
    word_t result;
    logic  equal;
    logic  taken;
    exec_t exe_q;

    assign a = dec_i.rs1_val;
    assign b = dec_i.op_b;

    always_comb begin
        case (dec_i.alu_op)
            ALU_ADD:    result = a + b;
            ALU_SUB:    result = a - b;
            ALU_AND:    result = a & b;
            ALU_OR:     result = a | b;
            ALU_XOR:    result = a ^ b;
            // signed compare, zero-extended flag
            ALU_SLT:    result = word_t'($signed(a) < $signed(b));
            ALU_PASS_B: result = b;
            default:    result = '0;
        endcase
    end

    // beq and bne share the comparator
    assign equal = (a == b);
    assign taken = dec_i.is_jal || (dec_i.is_branch && (equal ^ dec_i.br_ne));

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            exe_q.valid <= 1'b0;
        end else begin
            exe_q.valid    <= dec_i.valid;
            exe_q.pc       <= dec_i.pc;
            exe_q.result   <= result;
            exe_q.br_taken <= taken;
            exe_q.target   <= dec_i.pc + dec_i.imm;
            exe_q.rd       <= dec_i.rd;
            exe_q.wr_en    <= dec_i.wr_en;
            exe_q.is_jal   <= dec_i.is_jal;
            exe_q.illegal  <= dec_i.illegal;
        end
    end

    assign exe_o = exe_q;

endmodule

`default_nettype wire

/* src/reg_file.sv */
`timescale 1ns/10ps
`default_nettype none

`include "rv_core_defs.svh"

module reg_file import rv_core_pkg::*; (
    input  wire      clk,
    input  wire      rst_n_i,
    input  reg_idx_t rs1_idx_i,
    input  reg_idx_t rs2_idx_i,
    input  logic     we_i,
    input  reg_idx_t rd_i,
    input  word_t    wd_i,
    output word_t    rs1_data_o,
    output word_t    rs2_data_o
);

    word_t regs_q [`RV_NUM_REGS];

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            for (int i = 0; i < `RV_NUM_REGS; i++) begin
                regs_q[i] <= '0;
            end
        end else if (we_i && (rd_i != 5'd0)) begin
            regs_q[rd_i] <= wd_i;
        end
    end

    // x0 is hardwired to zero
    assign rs1_data_o = (rs1_idx_i == 5'd0) ? '0 : regs_q[rs1_idx_i];
    assign rs2_data_o = (rs2_idx_i == 5'd0) ? '0 : regs_q[rs2_idx_i];

endmodule

`default_nettype wire

/* src/result_writeback.sv */
`timescale 1ns/10ps
`default_nettype none

module result_writeback import rv_core_pkg::*; (
    input  wire      clk,
    input  wire      rst_n_i,
    input  exec_t    exe_i,
    output logic     we_o,
    output reg_idx_t rd_o,
    output word_t    wd_o,
    output wb_t      wb_o,
    output logic     next_valid_o,
    output addr_t    next_pc_o,
    output logic     halt_o
);

    addr_t pc_plus4;
    wb_t   wb_q;
    logic  next_valid_q;
    addr_t next_pc_q;
    logic  halt_q;

    assign pc_plus4 = exe_i.pc + 32'd4;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            wb_q.valid   <= 1'b0;
            next_valid_q <= 1'b0;
            halt_q       <= 1'b0;
        end else begin
            wb_q.valid   <= exe_i.valid && !exe_i.illegal && exe_i.wr_en;
            wb_q.pc      <= exe_i.pc;
            wb_q.rd      <= exe_i.rd;
            // jal links the return address
            wb_q.data    <= exe_i.is_jal ? pc_plus4 : exe_i.result;
            next_valid_q <= exe_i.valid && !exe_i.illegal;
            next_pc_q    <= exe_i.br_taken ? exe_i.target : pc_plus4;
            // sticky until reset
            halt_q       <= halt_q || (exe_i.valid && exe_i.illegal);
        end
    end

    assign we_o         = wb_q.valid;
    assign rd_o         = wb_q.rd;
    assign wd_o         = wb_q.data;
    assign wb_o         = wb_q;
    assign next_valid_o = next_valid_q;
    assign next_pc_o    = next_pc_q;
    assign halt_o       = halt_q;

endmodule

`default_nettype wire

/* src/rv_core_top.sv */
`timescale 1ns/10ps
`default_nettype none

module rv_core_top import rv_core_pkg::*; (
    input  wire   clk,
    input  wire   rst_n_i,
    input  byte_t mem_byte_i,
    output addr_t mem_addr_o,
    output logic  mem_req_o,
    output wb_t   wb_o,
    output logic  halt_o
);

    fetch_t   fetch;
    decode_t  dec;
    exec_t    exe;
    reg_idx_t rs1_idx;
    reg_idx_t rs2_idx;
    word_t    rs1_data;
    word_t    rs2_data;
    logic     we;
    reg_idx_t rd;
    word_t    wd;
    logic     next_valid;
    addr_t    next_pc;

    byte_fetch u_fetch (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .mem_byte_i   (mem_byte_i),
        .next_valid_i (next_valid),
        .next_pc_i    (next_pc),
        .halt_i       (halt_o),
        .mem_addr_o   (mem_addr_o),
        .mem_req_o    (mem_req_o),
        .fetch_o      (fetch)
    );

    inst_decode u_decode (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .fetch_i    (fetch),
        .rs1_data_i (rs1_data),
        .rs2_data_i (rs2_data),
        .rs1_idx_o  (rs1_idx),
        .rs2_idx_o  (rs2_idx),
        .dec_o      (dec)
    );

    alu_execute u_execute (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .dec_i   (dec),
        .exe_o   (exe)
    );

    reg_file u_regs (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .rs1_idx_i  (rs1_idx),
        .rs2_idx_i  (rs2_idx),
        .we_i       (we),
        .rd_i       (rd),
        .wd_i       (wd),
        .rs1_data_o (rs1_data),
        .rs2_data_o (rs2_data)
    );

    result_writeback u_result (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .exe_i        (exe),
        .we_o         (we),
        .rd_o         (rd),
        .wd_o         (wd),
        .wb_o         (wb_o),
        .next_valid_o (next_valid),
        .next_pc_o    (next_pc),
        .halt_o       (halt_o)
    );

endmodule

`default_nettype wire

/* testbench/rv_core_assert.sv */
`timescale 1ns/10ps
`default_nettype none

module rv_core_assert import rv_core_pkg::*; (
    input wire  clk,
    input wire  rst_n_i,
    input logic mem_req_i,
    input wb_t  wb_i,
    input logic halt_i
);

    int unsigned fail_cnt = 0;

    // a halted core starts no fetch
    halt_blocks_fetch: assert property (@(posedge clk) disable iff (!rst_n_i)
        halt_i |-> !mem_req_i)
    else begin
        fail_cnt++;
        $error("memory request while the core is halted");
    end

    // the illegal instruction itself leaves no trace
    halt_without_trace: assert property (@(posedge clk) disable iff (!rst_n_i)
        $rose(halt_i) |-> !wb_i.valid)
    else begin
        fail_cnt++;
        $error("write-back in the cycle halt rose");
    end

    wb_rd_nonzero: assert property (@(posedge clk) disable iff (!rst_n_i)
        wb_i.valid |-> (wb_i.rd != 5'd0))
    else begin
        fail_cnt++;
        $error("write-back traced for x0");
    end

endmodule

`default_nettype wire

/* testbench/rv_core_tb.sv */
`timescale 1ns/10ps
`default_nettype none

`include "rv_core_defs.svh"

module rv_core_tb import rv_core_pkg::*;;

    localparam int CLK_PERIOD   = 100;
    localparam int DRIVE_DELAY  = 5;
    localparam int RESET_CYCLES = 10;
    localparam int MEM_BYTES    = 256;
    localparam int N_ROWS       = 21;
    localparam int HALT_CYCLES  = 20;
    localparam int WATCHDOG_NS  = (N_ROWS + 4) * 9 * CLK_PERIOD + RESET_CYCLES * CLK_PERIOD;

    // one program word and the write-back it should produce
    typedef struct packed {
        logic [31:0] inst;
        logic        has_wb;
        reg_idx_t    rd;
        word_t       data;
        addr_t       pc;
    } row_t;

    logic  clk;
    logic  rst_n_i;
    byte_t mem_byte_i;
    addr_t mem_addr_o;
    logic  mem_req_o;
    wb_t   wb_o;
    logic  halt_o;

    row_t  rows [N_ROWS];
    string row_name [N_ROWS];
    byte_t mem [MEM_BYTES];
    addr_t addr_q;
    logic  req_q;
    int    row_count = 0;
    int    row_ptr = 0;
    int    mismatch_errors = 0;
    int    other_errors = 0;

    rv_core_top UUT (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .mem_byte_i (mem_byte_i),
        .mem_addr_o (mem_addr_o),
        .mem_req_o  (mem_req_o),
        .wb_o       (wb_o),
        .halt_o     (halt_o)
    );

    bind rv_core_top rv_core_assert u_assert (
        .clk       (clk),
        .rst_n_i   (rst_n_i),
        .mem_req_i (mem_req_o),
        .wb_i      (wb_o),
        .halt_i    (halt_o)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // instruction encoders
    function automatic logic [31:0] rtype_word(input logic [6:0] f7, input reg_idx_t rs2,
                                               input reg_idx_t rs1, input logic [2:0] f3,
                                               input reg_idx_t rd);
        return {f7, rs2, rs1, f3, rd, `RV_OP_REG};
    endfunction

    function automatic logic [31:0] itype_word(input logic [11:0] imm, input reg_idx_t rs1,
                                               input logic [2:0] f3, input reg_idx_t rd);
        return {imm, rs1, f3, rd, `RV_OP_IMM};
    endfunction

    function automatic logic [31:0] lui_word(input logic [19:0] imm, input reg_idx_t rd);
        return {imm, rd, `RV_OP_LUI};
    endfunction

    function automatic logic [31:0] branch_word(input logic [12:0] imm, input reg_idx_t rs2,
                                                input reg_idx_t rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], `RV_OP_BRANCH};
    endfunction

    function automatic logic [31:0] jal_word(input logic [20:0] imm, input reg_idx_t rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, `RV_OP_JAL};
    endfunction

    task automatic add_row(input string name, input logic [31:0] inst, input logic has_wb,
                           input reg_idx_t rd, input word_t data);
        rows[row_count].inst   = inst;
        rows[row_count].has_wb = has_wb;
        rows[row_count].rd     = rd;
        rows[row_count].data   = data;
        rows[row_count].pc     = addr_t'(row_count * 4);
        row_name[row_count]    = name;
        row_count++;
    endtask

    // rows sit at consecutive words from address zero
    task automatic build_program();
        add_row("addi_pos", itype_word(12'd5, 5'd0, 3'b000, 5'd1), 1'b1, 5'd1, 32'h0000_0005);
        add_row("addi_neg", itype_word(12'hffd, 5'd0, 3'b000, 5'd2), 1'b1, 5'd2, 32'hffff_fffd);
        add_row("add", rtype_word(7'h00, 5'd2, 5'd1, 3'b000, 5'd3), 1'b1, 5'd3, 32'h0000_0002);
        add_row("sub", rtype_word(7'h20, 5'd2, 5'd1, 3'b000, 5'd4), 1'b1, 5'd4, 32'h0000_0008);
        add_row("and", rtype_word(7'h00, 5'd2, 5'd1, 3'b111, 5'd5), 1'b1, 5'd5, 32'h0000_0005);
        add_row("or", rtype_word(7'h00, 5'd2, 5'd1, 3'b110, 5'd6), 1'b1, 5'd6, 32'hffff_fffd);
        add_row("xor", rtype_word(7'h00, 5'd2, 5'd1, 3'b100, 5'd7), 1'b1, 5'd7, 32'hffff_fff8);
        // -3 < 5 signed
        add_row("slt_neg", rtype_word(7'h00, 5'd1, 5'd2, 3'b010, 5'd8), 1'b1, 5'd8, 32'h1);
        add_row("slt_pos", rtype_word(7'h00, 5'd2, 5'd1, 3'b010, 5'd9), 1'b1, 5'd9, 32'h0);
        add_row("lui", lui_word(20'h12345, 5'd10), 1'b1, 5'd10, 32'h1234_5000);
        add_row("addi_x0", itype_word(12'd7, 5'd1, 3'b000, 5'd0), 1'b0, 5'd0, 32'h0);
        add_row("read_x0", rtype_word(7'h00, 5'd1, 5'd0, 3'b000, 5'd11), 1'b1, 5'd11, 32'h5);
        // taken branch lands on 0x38
        add_row("beq_taken", branch_word(13'd8, 5'd1, 5'd1, 3'b000), 1'b0, 5'd0, 32'h0);
        add_row("beq_skip", itype_word(12'd99, 5'd0, 3'b000, 5'd12), 1'b0, 5'd0, 32'h0);
        add_row("bne_not_taken", branch_word(13'd8, 5'd1, 5'd1, 3'b001), 1'b0, 5'd0, 32'h0);
        add_row("after_bne", itype_word(12'h7ff, 5'd0, 3'b000, 5'd13), 1'b1, 5'd13, 32'h7ff);
        // links 0x44 and jumps to 0x4c
        add_row("jal", jal_word(21'd12, 5'd14), 1'b1, 5'd14, 32'h0000_0044);
        add_row("jal_skip_a", itype_word(12'd1, 5'd0, 3'b000, 5'd15), 1'b0, 5'd0, 32'h0);
        add_row("jal_skip_b", itype_word(12'd2, 5'd0, 3'b000, 5'd15), 1'b0, 5'd0, 32'h0);
        add_row("jal_target", itype_word(12'hffc, 5'd14, 3'b000, 5'd16), 1'b1, 5'd16, 32'h40);
        add_row("illegal", 32'h0000_0000, 1'b0, 5'd0, 32'h0);
    endtask

    // unused bytes read as zero and form an illegal word
    task automatic load_memory();
        for (int i = 0; i < MEM_BYTES; i++) begin
            mem[i] = 8'h00;
        end
        for (int r = 0; r < N_ROWS; r++) begin
            for (int b = 0; b < 4; b++) begin
                mem[4 * r + b] = rows[r].inst[8 * b +: 8];
            end
        end
    endtask

    // address and request are stable by the falling edge
    always @(negedge clk) begin
        addr_q = mem_addr_o;
        req_q  = mem_req_o;
    end

    // byte returns one cycle after a requested address
    always @(posedge clk) begin
        #(DRIVE_DELAY);
        if (req_q && addr_q < MEM_BYTES) begin
            mem_byte_i = mem[addr_q];
        end else begin
            mem_byte_i = 8'h00;
        end
    end

    task automatic check_reset_outputs();
        assert (!mem_req_o && !wb_o.valid && !halt_o) else begin
            other_errors++;
            $display("error: outputs active during reset (req %b, wb valid %b, halt %b)",
                     mem_req_o, wb_o.valid, halt_o);
        end
    endtask

    task automatic skip_silent_rows();
        while (row_ptr < N_ROWS && !rows[row_ptr].has_wb) begin
            row_ptr++;
        end
    endtask

    task automatic check_writeback();
        row_t exp;
        skip_silent_rows();
        assert (row_ptr < N_ROWS) else begin
            other_errors++;
            $display("error: write-back to x%0d at pc %08h arrived after the last expected row",
                     wb_o.rd, wb_o.pc);
        end
        if (row_ptr < N_ROWS) begin
            exp = rows[row_ptr];
            assert (wb_o.rd == exp.rd) else begin
                mismatch_errors++;
                $display("mismatch %s rd: expected x%0d, actual x%0d",
                         row_name[row_ptr], exp.rd, wb_o.rd);
            end
            assert (wb_o.data == exp.data) else begin
                mismatch_errors++;
                $display("mismatch %s data: expected %08h, actual %08h",
                         row_name[row_ptr], exp.data, wb_o.data);
            end
            assert (wb_o.pc == exp.pc) else begin
                mismatch_errors++;
                $display("mismatch %s pc: expected %08h, actual %08h",
                         row_name[row_ptr], exp.pc, wb_o.pc);
            end
            row_ptr++;
        end
    endtask

    task automatic check_all_consumed();
        skip_silent_rows();
        assert (row_ptr == N_ROWS) else begin
            other_errors++;
            $display("error: core halted before the write-back of row %s", row_name[row_ptr]);
        end
    endtask

    task automatic check_halted_cycle();
        assert (!mem_req_o) else begin
            other_errors++;
            $display("error: memory request at address %08h after halt", mem_addr_o);
        end
        assert (!wb_o.valid) else begin
            other_errors++;
            $display("error: write-back to x%0d after halt", wb_o.rd);
        end
        assert (halt_o) else begin
            other_errors++;
            $display("error: halt dropped without a reset");
        end
    endtask

    task automatic finish_run();
        int assert_errors;
        assert_errors = UUT.u_assert.fail_cnt;
        other_errors += assert_errors;
        $display("summary: %0d mismatches, %0d other errors", mismatch_errors, other_errors);
        if (mismatch_errors == 0 && other_errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    endtask

    initial begin : main
        bit halted;
        halted     = 1'b0;
        rst_n_i    = 1'b0;
        mem_byte_i = 8'h00;
        build_program();
        load_memory();
        repeat (RESET_CYCLES) begin
            @(posedge clk);
            @(negedge clk);
            check_reset_outputs();
        end
        @(posedge clk);
        #(DRIVE_DELAY);
        rst_n_i = 1'b1;
        // outputs are sampled mid-cycle
        while (!halted) begin
            @(negedge clk);
            if (wb_o.valid) begin
                check_writeback();
            end
            halted = halt_o;
        end
        check_all_consumed();
        repeat (HALT_CYCLES) begin
            @(negedge clk);
            check_halted_cycle();
        end
        finish_run();
    end

    initial begin : watchdog
        #(WATCHDOG_NS);
        other_errors++;
        $display("error: timeout after %0d ns without reaching halt", WATCHDOG_NS);
        finish_run();
    end

endmodule

`default_nettype wire

/* flist.f */
+incdir+src
src/rv_core_pkg.sv
src/byte_fetch.sv
src/inst_decode.sv
src/alu_execute.sv
src/reg_file.sv
src/result_writeback.sv
src/rv_core_top.sv
testbench/rv_core_assert.sv
testbench/rv_core_tb.sv

/* Bender.yml */
package:
  name: rv_core

sources:
  - include_dirs:
      - src
    files:
      - src/rv_core_pkg.sv
      - src/byte_fetch.sv
      - src/inst_decode.sv
      - src/alu_execute.sv
      - src/reg_file.sv
      - src/result_writeback.sv
      - src/rv_core_top.sv
  - target: test
    include_dirs:
      - src
    files:
      - testbench/rv_core_assert.sv
      - testbench/rv_core_tb.sv
